/* src/huff_consts.svh */
// sizing macros for the Huffman encoder, included by the package and the RTL stages
`ifndef HUFF_CONSTS_SVH
`define HUFF_CONSTS_SVH

// symbols per frame and input weight width
`define HUFF_NUM_SYMBOLS 8
`define HUFF_IN_WEIGHT_W 3

// node fields, all-ones weight marks an empty slot
`define HUFF_NODE_WEIGHT_W 6
`define HUFF_NODE_ID_W 4

// code table
`define HUFF_CODE_W 7
`define HUFF_LEN_W 3

// output side
`define HUFF_OUT_SYMBOLS 5
`define HUFF_CODE_SLOTS 2

`endif

/* src/huff_pkg.sv */
// node, code and frame types shared by the three encoder stages, imported by each module
`include "huff_consts.svh"

package huff_pkg;

    // ids 0-7 leaves, 8-14 merged nodes, 15 empty
    typedef struct packed {
        logic [`HUFF_NODE_ID_W-1:0]     id;
        logic [`HUFF_NODE_WEIGHT_W-1:0] weight;
        logic [`HUFF_NUM_SYMBOLS-1:0]   mask;
    } huff_node_t;

    typedef huff_node_t [`HUFF_NUM_SYMBOLS-1:0] node_list_t;

    typedef struct packed {
        logic       mode;
        node_list_t nodes;
    } sorted_frame_t;

    // code bit 0 is the bit nearest the root
    typedef struct packed {
        logic [`HUFF_CODE_W-1:0] code;
        logic [`HUFF_LEN_W-1:0]  len;
    } code_entry_t;

    typedef struct packed {
        logic                                mode;
        code_entry_t [`HUFF_NUM_SYMBOLS-1:0] entries;
    } code_frame_t;

    localparam huff_node_t EMPTY_NODE = '{id: '1, weight: '1, mask: '0};

    // insert ahead of all equal weights, last slot falls off the end
    function automatic node_list_t insert_node(node_list_t list, huff_node_t node);
        node_list_t                   res;
        logic [`HUFF_NUM_SYMBOLS-1:0] lt;
        for (int i = 0; i < `HUFF_NUM_SYMBOLS; i++) begin
            lt[i] = list[i].weight < node.weight;
        end
        res[0] = lt[0] ? list[0] : node;
        for (int i = 1; i < `HUFF_NUM_SYMBOLS; i++) begin
            res[i] = lt[i] ? list[i] : (lt[i-1] ? node : list[i-1]);
        end
        return res;
    endfunction

endpackage

/* src/huff_leaf_sorter.sv */
// stage 1 of the encoder, takes eight weights per frame and hands over a sorted leaf list
`timescale 1ns/100ps
`include "huff_consts.svh"

module huff_leaf_sorter
    import huff_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [`HUFF_IN_WEIGHT_W-1:0] in_weight,
    input  logic                         out_mode,
    input  logic                         sort_credit,
    output logic                         in_ready,
    output logic                         sort_valid,
    output sorted_frame_t                sort_frame
);

    localparam int SYM_W  = $clog2(`HUFF_NUM_SYMBOLS);
    localparam int ID_W   = `HUFF_NODE_ID_W;
    localparam int NODE_W = `HUFF_NODE_WEIGHT_W;
    localparam logic [SYM_W-1:0] FIRST_SYM = SYM_W'(`HUFF_NUM_SYMBOLS - 1);

    logic [SYM_W-1:0] sym_id;
    logic             frame_full;
    logic             credit;
    logic             accept;
    logic             mode_q;
    node_list_t       leaves;
    node_list_t       base_list;
    huff_node_t       new_leaf;

    assign accept     = in_valid & in_ready;
    assign in_ready   = ~frame_full;
    assign sort_valid = frame_full & credit;

    // ============================================================
    // leaf build and insertion
    // ============================================================

    always_comb begin
        // first beat of a frame starts from an empty list
        base_list = (sym_id == FIRST_SYM) ? {`HUFF_NUM_SYMBOLS{EMPTY_NODE}} : leaves;
        new_leaf.id     = ID_W'(sym_id);
        new_leaf.weight = NODE_W'(in_weight);
        new_leaf.mask   = '0;
        new_leaf.mask[sym_id] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            leaves <= insert_node(base_list, new_leaf);
            if (sym_id == FIRST_SYM) begin
                mode_q <= out_mode;
            end
        end
    end

    assign sort_frame.mode  = mode_q;
    assign sort_frame.nodes = leaves;

    // ============================================================
    // beat count and handover credit
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sym_id     <= FIRST_SYM;
            frame_full <= 1'b0;
            credit     <= 1'b1;
        end else begin
            // symbols arrive 7 down to 0, wraps for the next frame
            if (accept) begin
                sym_id <= sym_id - 1'b1;
            end
            if (accept && sym_id == '0) begin
                frame_full <= 1'b1;
            end else if (sort_valid) begin
                frame_full <= 1'b0;
            end
            credit <= (credit & ~sort_valid) | sort_credit;
        end
    end

endmodule

/* src/huff_tree_merger.sv */
// stage 2 of the encoder, merges the two lightest nodes per cycle and grows each symbol code
`timescale 1ns/100ps
`include "huff_consts.svh"

module huff_tree_merger
    import huff_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          sort_valid,
    input  sorted_frame_t sort_frame,
    input  logic          code_credit,
    output logic          sort_credit,
    output logic          code_valid,
    output code_frame_t   code_frame
);

    localparam int ID_W  = `HUFF_NODE_ID_W;
    localparam int CNT_W = $clog2(`HUFF_NUM_SYMBOLS - 1);
    localparam int CRD_W = $clog2(`HUFF_CODE_SLOTS + 1);
    localparam logic [CNT_W-1:0] LAST_MERGE = CNT_W'(`HUFF_NUM_SYMBOLS - 2);

    node_list_t                          nodes;
    node_list_t                          rest;
    huff_node_t                          node_a;
    huff_node_t                          node_b;
    huff_node_t                          merged;
    code_entry_t [`HUFF_NUM_SYMBOLS-1:0] codes;
    code_entry_t [`HUFF_NUM_SYMBOLS-1:0] codes_next;
    code_frame_t                         out_frame;
    logic [CNT_W-1:0]                    merge_cnt;
    logic [CRD_W-1:0]                    credit_cnt;
    logic                                busy;
    logic                                pending;
    logic                                mode_q;
    logic                                out_free;
    logic                                last_step;
    logic                                step;

    // ============================================================
    // one merge step
    // ============================================================

    always_comb begin
        node_a = nodes[0];
        node_b = nodes[1];

        merged.id     = ID_W'(`HUFF_NUM_SYMBOLS) + ID_W'(merge_cnt);
        merged.weight = node_a.weight + node_b.weight;
        merged.mask   = node_a.mask | node_b.mask;

        // drop the two lowest, pad the tail with empties
        for (int i = 0; i < `HUFF_NUM_SYMBOLS - 2; i++) begin
            rest[i] = nodes[i+2];
        end
        rest[`HUFF_NUM_SYMBOLS-2] = EMPTY_NODE;
        rest[`HUFF_NUM_SYMBOLS-1] = EMPTY_NODE;

        // position 0 is the right branch and gets a 1, new bit goes at the root end
        for (int i = 0; i < `HUFF_NUM_SYMBOLS; i++) begin
            codes_next[i] = codes[i];
            if (node_a.mask[i] | node_b.mask[i]) begin
                codes_next[i].code = {codes[i].code[`HUFF_CODE_W-2:0], node_a.mask[i]};
                codes_next[i].len  = codes[i].len + 1'b1;
            end
        end
    end

    // ============================================================
    // flow control
    // ============================================================

    // the last merge needs room in the output register
    assign out_free    = ~pending | code_valid;
    assign last_step   = merge_cnt == LAST_MERGE;
    assign step        = busy & (~last_step | out_free);
    assign sort_credit = step & last_step;
    assign code_valid  = pending & (credit_cnt != '0);
    assign code_frame  = out_frame;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            pending    <= 1'b0;
            merge_cnt  <= '0;
            credit_cnt <= CRD_W'(`HUFF_CODE_SLOTS);
        end else begin
            if (sort_valid) begin
                busy      <= 1'b1;
                merge_cnt <= '0;
            end else if (step) begin
                merge_cnt <= merge_cnt + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                end
            end
            if (sort_credit) begin
                pending <= 1'b1;
            end else if (code_valid) begin
                pending <= 1'b0;
            end
            credit_cnt <= credit_cnt + CRD_W'(code_credit) - CRD_W'(code_valid);
        end
    end

    // ============================================================
    // working list, codes and finished table
    // ============================================================

    always_ff @(posedge clk) begin
        if (sort_valid) begin
            nodes  <= sort_frame.nodes;
            mode_q <= sort_frame.mode;
            codes  <= '0;
        end else if (step) begin
            nodes <= insert_node(rest, merged);
            codes <= codes_next;
        end
        if (sort_credit) begin
            out_frame.mode    <= mode_q;
            out_frame.entries <= codes_next;
        end
    end

endmodule

/* src/huff_code_serializer.sv */
// stage 3 of the encoder, buffers finished code tables and shifts out five codes per frame
`timescale 1ns/100ps
`include "huff_consts.svh"

module huff_code_serializer
    import huff_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        code_valid,
    input  code_frame_t code_frame,
    output logic        code_credit,
    output logic        out_valid,
    output logic        out_code
);

    localparam int SYM_W = $clog2(`HUFF_NUM_SYMBOLS);
    localparam int POS_W = $clog2(`HUFF_OUT_SYMBOLS);
    localparam int PTR_W = $clog2(`HUFF_CODE_SLOTS);
    localparam int CNT_W = $clog2(`HUFF_CODE_SLOTS + 1);
    localparam logic [POS_W-1:0] LAST_POS = POS_W'(`HUFF_OUT_SYMBOLS - 1);

    // emission order per mode
    localparam logic [SYM_W-1:0] ORDER_M0 [`HUFF_OUT_SYMBOLS] = '{3'd3, 3'd2, 3'd1, 3'd0, 3'd4};
    localparam logic [SYM_W-1:0] ORDER_M1 [`HUFF_OUT_SYMBOLS] = '{3'd3, 3'd5, 3'd2, 3'd7, 3'd6};

    code_frame_t             slots [`HUFF_CODE_SLOTS];
    code_frame_t             cur_frame;
    code_entry_t             cur_entry;
    logic [SYM_W-1:0]        cur_sym;
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        fill_cnt;
    logic [POS_W-1:0]        sym_pos;
    logic [`HUFF_LEN_W-1:0]  bit_pos;
    logic                    active;
    logic                    last_bit;
    logic                    last_sym;
    logic                    frame_done;
    logic                    done_q;

    always_ff @(posedge clk) begin
        if (code_valid) begin
            slots[wr_ptr] <= code_frame;
        end
    end

    // ============================================================
    // current bit select
    // ============================================================

    always_comb begin
        cur_frame = slots[rd_ptr];
        cur_sym   = cur_frame.mode ? ORDER_M1[sym_pos] : ORDER_M0[sym_pos];
        cur_entry = cur_frame.entries[cur_sym];
    end

    assign active     = fill_cnt != '0;
    assign last_bit   = bit_pos == cur_entry.len - 1'b1;
    assign last_sym   = sym_pos == LAST_POS;
    assign frame_done = active & last_bit & last_sym;

    // ============================================================
    // pointers, position counters and output
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill_cnt    <= '0;
            sym_pos     <= '0;
            bit_pos     <= '0;
            out_valid   <= 1'b0;
            out_code    <= 1'b0;
            done_q      <= 1'b0;
            code_credit <= 1'b0;
        end else begin
            if (code_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (frame_done) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill_cnt <= fill_cnt + CNT_W'(code_valid) - CNT_W'(frame_done);

            if (active) begin
                if (last_bit) begin
                    bit_pos <= '0;
                    sym_pos <= last_sym ? '0 : sym_pos + 1'b1;
                end else begin
                    bit_pos <= bit_pos + 1'b1;
                end
            end

            out_valid <= active;
            out_code  <= active & cur_entry.code[bit_pos];

            // slot is returned once its last bit is on the pin
            done_q      <= frame_done;
            code_credit <= done_q;
        end
    end

endmodule

/* src/huff_encoder_top.sv */
// top level of the Huffman encoder, chains sorter, merger and serializer over credit links
`timescale 1ns/100ps
`include "huff_consts.svh"

module huff_encoder_top
    import huff_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [`HUFF_IN_WEIGHT_W-1:0] in_weight,
    input  logic                         out_mode,
    output logic                         in_ready,
    output logic                         out_valid,
    output logic                         out_code
);

    // link A, sorter to merger
    logic          sort_valid;
    sorted_frame_t sort_frame;
    logic          sort_credit;

    // link B, merger to serializer
    logic          code_valid;
    code_frame_t   code_frame;
    logic          code_credit;

    huff_leaf_sorter i_sorter (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_weight  (in_weight),
        .out_mode   (out_mode),
        .sort_credit(sort_credit),
        .in_ready   (in_ready),
        .sort_valid (sort_valid),
        .sort_frame (sort_frame)
    );

    huff_tree_merger i_merger (
        .clk        (clk),
        .rst_n      (rst_n),
        .sort_valid (sort_valid),
        .sort_frame (sort_frame),
        .code_credit(code_credit),
        .sort_credit(sort_credit),
        .code_valid (code_valid),
        .code_frame (code_frame)
    );

    huff_code_serializer i_serializer (
        .clk        (clk),
        .rst_n      (rst_n),
        .code_valid (code_valid),
        .code_frame (code_frame),
        .code_credit(code_credit),
        .out_valid  (out_valid),
        .out_code   (out_code)
    );

endmodule

/* tb/huff_encoder_properties.sv */
// protocol assertions on the encoder top level and its two credit links, attached by bind
`timescale 1ns/100ps
`include "huff_consts.svh"

module huff_encoder_properties (
    input logic clk,
    input logic rst_n,
    input logic in_ready,
    input logic out_valid,
    input logic out_code,
    input logic sort_valid,
    input logic sort_credit,
    input logic code_valid,
    input logic code_credit
);

    logic [1:0] sort_held;
    logic [1:0] slots_used;

    // link mirrors, sorter holds one credit and the serializer starts empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sort_held  <= 2'd1;
            slots_used <= '0;
        end else begin
            sort_held  <= sort_held - 2'(sort_valid) + 2'(sort_credit);
            slots_used <= slots_used + 2'(code_valid) - 2'(code_credit);
        end
    end

    reset_idle: assert property (@(posedge clk)
        !rst_n |-> in_ready && !out_valid && !out_code && !sort_valid && !code_valid)
    else $error("outputs left their reset values while rst_n was low");

    sort_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        sort_valid |-> sort_held != 0)
    else $error("sort_valid pulsed without a credit");

    sort_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sort_valid |=> !sort_valid)
    else $error("sort_valid stayed high for more than one cycle");

    sort_credit_owed: assert property (@(posedge clk) disable iff (!rst_n)
        sort_credit |-> sort_held == 0)
    else $error("sort_credit returned while the sorter still held its credit");

    code_has_room: assert property (@(posedge clk) disable iff (!rst_n)
        code_valid |-> slots_used < `HUFF_CODE_SLOTS)
    else $error("code_valid arrived while both serializer slots were full");

    code_credit_owed: assert property (@(posedge clk) disable iff (!rst_n)
        code_credit |-> slots_used != 0)
    else $error("code_credit returned with no slot in use");

endmodule

bind huff_encoder_top huff_encoder_properties i_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_code   (out_code),
    .sort_valid (sort_valid),
    .sort_credit(sort_credit),
    .code_valid (code_valid),
    .code_credit(code_credit)
);

/* tb/huff_encoder_tb.sv */
// testbench for the Huffman encoder that drives corner and random frames and checks every output bit
`timescale 1ns/100ps
`include "huff_consts.svh"

module huff_encoder_tb;

    localparam int NUM_RANDOM   = 40;
    localparam int NUM_FRAMES   = 3 + NUM_RANDOM;
    localparam int LIMIT_CYCLES = NUM_FRAMES * 60 + 200;
    localparam int DRAIN_IDLE   = 100;

    logic                         clk;
    logic                         rst_n;
    logic                         in_valid;
    logic [`HUFF_IN_WEIGHT_W-1:0] in_weight;
    logic                         out_mode;
    logic                         in_ready;
    logic                         out_valid;
    logic                         out_code;

    integer     seed;
    bit         exp_q [$];
    logic       exp_bit;
    logic       exp_avail;
    logic [2:0] beat_cnt;
    int         frames_in;

    // reference model state with frame_w indexed by symbol
    logic [`HUFF_IN_WEIGHT_W-1:0] frame_w [`HUFF_NUM_SYMBOLS];
    int                           ref_w [`HUFF_NUM_SYMBOLS];
    logic [`HUFF_NUM_SYMBOLS-1:0] ref_m [`HUFF_NUM_SYMBOLS];
    int                           ref_cnt;

    huff_encoder_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_weight(in_weight),
        .out_mode (out_mode),
        .in_ready (in_ready),
        .out_valid(out_valid),
        .out_code (out_code)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    // ============================================================
    // reference model
    // ============================================================

    // new node goes ahead of every node of equal weight
    task automatic insert_by_weight(input int w, input logic [`HUFF_NUM_SYMBOLS-1:0] m);
        int pos;
        pos = 0;
        while (pos < ref_cnt && ref_w[pos] < w) begin
            pos++;
        end
        for (int j = ref_cnt; j > pos; j--) begin
            ref_w[j] = ref_w[j-1];
            ref_m[j] = ref_m[j-1];
        end
        ref_w[pos] = w;
        ref_m[pos] = m;
        ref_cnt++;
    endtask

    task automatic build_expected(input logic mode);
        logic [`HUFF_CODE_W-1:0]      code [`HUFF_NUM_SYMBOLS];
        int                           len [`HUFF_NUM_SYMBOLS];
        int                           order [`HUFF_OUT_SYMBOLS];
        logic [`HUFF_NUM_SYMBOLS-1:0] m0;
        logic [`HUFF_NUM_SYMBOLS-1:0] m1;
        int                           mw;
        int                           sym;
        ref_cnt = 0;
        for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
            code[s] = '0;
            len[s]  = 0;
        end
        for (int s = `HUFF_NUM_SYMBOLS - 1; s >= 0; s--) begin
            insert_by_weight(frame_w[s], 8'b1 << s);
        end
        for (int k = 0; k < `HUFF_NUM_SYMBOLS - 1; k++) begin
            m0 = ref_m[0];
            m1 = ref_m[1];
            mw = ref_w[0] + ref_w[1];
            // lightest node is the 1 branch and older bits move away from the root
            for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
                if (m0[s] || m1[s]) begin
                    code[s] = (code[s] << 1) | 7'(m0[s]);
                    len[s]++;
                end
            end
            for (int j = 2; j < ref_cnt; j++) begin
                ref_w[j-2] = ref_w[j];
                ref_m[j-2] = ref_m[j];
            end
            ref_cnt -= 2;
            insert_by_weight(mw, m0 | m1);
        end
        if (mode) begin
            order = '{3, 5, 2, 7, 6};
        end else begin
            order = '{3, 2, 1, 0, 4};
        end
        for (int p = 0; p < `HUFF_OUT_SYMBOLS; p++) begin
            sym = order[p];
            for (int b = 0; b < len[sym]; b++) begin
                exp_q.push_back(code[sym][b]);
            end
        end
    endtask

    // ============================================================
    // stimulus
    // ============================================================

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid  = 1'b0;
            in_weight = 3'($random(seed));
            out_mode  = 1'($random(seed));
        end
    endtask

    // holds the beat until in_ready is seen high before a rising edge
    task automatic send_beat(input logic [`HUFF_IN_WEIGHT_W-1:0] w, input logic mode_bit);
        @(negedge clk);
        in_valid  = 1'b1;
        in_weight = w;
        out_mode  = mode_bit;
        while (!in_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic send_frame(input logic mode, input int gap_max);
        int gap;
        build_expected(mode);
        for (int s = `HUFF_NUM_SYMBOLS - 1; s >= 0; s--) begin
            gap = (gap_max > 0) ? ($unsigned($random(seed)) % (gap_max + 1)) : 0;
            idle_cycles(gap);
            // mode only counts on the first beat
            send_beat(frame_w[s], (s == `HUFF_NUM_SYMBOLS - 1) ? mode : 1'($random(seed)));
        end
    endtask

    initial begin
        int quiet_cycles;
        seed      = 32'h1888_4299;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_weight = '0;
        out_mode  = 1'b0;
        exp_bit   = 1'b0;
        exp_avail = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
            frame_w[s] = 3'd3;
        end
        send_frame(1'b0, 0);
        for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
            frame_w[s] = 3'd7;
        end
        send_frame(1'b1, 0);
        // pairs of ties
        frame_w = '{3'd1, 3'd1, 3'd2, 3'd2, 3'd4, 3'd1, 3'd6, 3'd2};
        send_frame(1'b0, 2);

        for (int f = 0; f < NUM_RANDOM; f++) begin
            for (int s = 0; s < `HUFF_NUM_SYMBOLS; s++) begin
                frame_w[s] = 3'($random(seed));
            end
            send_frame(1'($random(seed)), (f % 4 == 0) ? 0 : 3);
        end
        @(negedge clk);
        in_valid = 1'b0;

        // drain until every expected bit is out or the output has gone quiet
        quiet_cycles = 0;
        while (exp_q.size() != 0 && quiet_cycles < DRAIN_IDLE) begin
            @(negedge clk);
            quiet_cycles = out_valid ? 0 : quiet_cycles + 1;
        end
        repeat (20) @(negedge clk);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("run ended with %0d bits still expected", exp_q.size()));
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        fail_run($sformatf("timeout, run did not finish within %0d cycles", LIMIT_CYCLES));
    end

    // ============================================================
    // checking
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt  <= '0;
            frames_in <= 0;
        end else if (in_valid && in_ready) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == 3'd7) begin
                frames_in <= frames_in + 1;
            end
        end
    end

    // next expected bit is taken mid-cycle while the output bit is stable
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_avail = 1'b0;
        end else if (out_valid) begin
            if (exp_q.size() > 0) begin
                exp_bit   = exp_q.pop_front();
                exp_avail = 1'b1;
            end else begin
                exp_avail = 1'b0;
            end
        end
    end

    bit_matches: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && exp_avail |-> out_code == exp_bit)
    else fail_run($sformatf("MISMATCH at %0t: out_code is %0b, expected %0b",
                            $time, $sampled(out_code), exp_bit));

    no_extra_bits: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> exp_avail)
    else fail_run($sformatf("at %0t the encoder sent a bit when no bit was expected", $time));

    idle_before_first: assert property (@(posedge clk) disable iff (!rst_n)
        frames_in == 0 |-> in_ready && !out_valid)
    else fail_run($sformatf("at %0t the encoder stalled or sent output before any frame",
                            $time));

    ready_drops: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_ready && beat_cnt == 3'd7 |=> !in_ready)
    else fail_run($sformatf("at %0t in_ready stayed high after the last beat of a frame",
                            $time));

endmodule

/* src.f */
+incdir+src
src/huff_pkg.sv
src/huff_leaf_sorter.sv
src/huff_tree_merger.sv
src/huff_code_serializer.sv
src/huff_encoder_top.sv
tb/huff_encoder_properties.sv
tb/huff_encoder_tb.sv

/* Bender.yml */
package:
  name: huff_encoder

sources:
  - include_dirs:
      - src
    files:
      - src/huff_pkg.sv
      - src/huff_leaf_sorter.sv
      - src/huff_tree_merger.sv
      - src/huff_code_serializer.sv
      - src/huff_encoder_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/huff_encoder_properties.sv
      - tb/huff_encoder_tb.sv
